/* rtl/ioDisplayPkg.sv */
package ioDisplayPkg;

    localparam int DEKATRON_WIDTH = 4;

    // Digit counts of the displayed registers
    localparam int IP_DEKATRON_NUM   = 6;
    localparam int AP_DEKATRON_NUM   = 4;
    localparam int DATA_DEKATRON_NUM = 3;
    localparam int LOOP_DEKATRON_NUM = 3;

    localparam int ANODE_COUNT = 10;   // Multiplexed tube pairs

    localparam int KB_COLUMNS     = 8;
    localparam int KB_ROWS        = 5;
    localparam int KEY_CODE_WIDTH = 6; // Holds column * KB_ROWS + row

    localparam int SCAN_DIVISOR_DEFAULT = 4000; // 4 ms at 1 us
    localparam int PHASE_CYCLES         = 2;

    localparam logic [7:0] KB_READ_CODE = 8'h09;

    localparam int EVENT_FIFO_DEPTH = 4;
    localparam int KEY_CREDITS      = 2;  // Host buffer size

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        CATHODE,
        ANODE,
        KB_WRITE,
        KB_READ,
        STOP
    } panelPhaseT;

    // IN-12 cathode wiring, pin 15 leaves the tube dark
    function automatic logic [3:0] nixiePin(input logic [DEKATRON_WIDTH-1:0] digit);
        case (digit)
            4'd0:    nixiePin = 4'd1;
            4'd1:    nixiePin = 4'd0;
            4'd2:    nixiePin = 4'd9;
            4'd3:    nixiePin = 4'd8;
            4'd4:    nixiePin = 4'd7;
            4'd5:    nixiePin = 4'd6;
            4'd6:    nixiePin = 4'd5;
            4'd7:    nixiePin = 4'd4;
            4'd8:    nixiePin = 4'd3;
            4'd9:    nixiePin = 4'd2;
            default: nixiePin = 4'd15;
        endcase
    endfunction

endpackage

/* rtl/busSequencer.sv */
`timescale 1ns/1ps

module busSequencer import ioDisplayPkg::*; #(
    parameter int scanDivisor = SCAN_DIVISOR_DEFAULT
) (
    input  logic       Clock_1us,
    input  logic       rstN,
    input  logic [7:0] cathodeData,
    input  logic [3:0] anodeIndex,
    input  logic [7:0] columnSelect,
    output logic [7:0] emulData,
    output logic       in12WriteAnode,
    output logic       in12WriteCathode,
    output logic       in12ClearN,
    output logic       keyboardWrite,
    output logic       keyboardRead,
    output logic       frameDone
);

    localparam int tickWidth  = $clog2(scanDivisor);
    localparam int cycleWidth = (PHASE_CYCLES > 1) ? $clog2(PHASE_CYCLES) : 1;

    logic [tickWidth-1:0]  tickCount;
    logic                  scanTick;
    panelPhaseT            phase;
    panelPhaseT            nextPhase;
    logic [cycleWidth-1:0] cycleCount;
    logic [cycleWidth-1:0] nextCycle;
    logic                  nextStrobe;
    logic [7:0]            nextBus;

    assign scanTick = (tickCount == tickWidth'(scanDivisor - 1));

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            tickCount <= '0;
        end else if (scanTick) begin
            tickCount <= '0;
        end else begin
            tickCount <= tickCount + 1'b1;
        end
    end

    always_comb begin
        nextPhase = phase;
        nextCycle = cycleCount + 1'b1;
        if (phase == IDLE) begin
            nextCycle = '0;
            if (scanTick) begin
                nextPhase = CLEAR;
            end
        end else if (cycleCount == cycleWidth'(PHASE_CYCLES - 1)) begin
            nextCycle = '0;
            case (phase)
                CLEAR:    nextPhase = CATHODE;
                CATHODE:  nextPhase = ANODE;
                ANODE:    nextPhase = KB_WRITE;
                KB_WRITE: nextPhase = KB_READ;
                KB_READ:  nextPhase = STOP;
                default:  nextPhase = IDLE;
            endcase
        end
    end

    // Strobes sit in the last cycle of their phase
    assign nextStrobe = (nextPhase != IDLE) && (nextCycle == cycleWidth'(PHASE_CYCLES - 1));

    always_comb begin
        case (nextPhase)
            CATHODE:  nextBus = cathodeData;
            ANODE:    nextBus = {4'b0000, anodeIndex};
            KB_WRITE: nextBus = columnSelect;
            KB_READ:  nextBus = KB_READ_CODE;
            default:  nextBus = 8'h00;             // Idle, clear and stop
        endcase
    end

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            phase            <= IDLE;
            cycleCount       <= '0;
            emulData         <= 8'h00;
            in12ClearN       <= 1'b1;
            in12WriteCathode <= 1'b0;
            in12WriteAnode   <= 1'b0;
            keyboardWrite    <= 1'b0;
            keyboardRead     <= 1'b0;
            frameDone        <= 1'b0;
        end else begin
            phase            <= nextPhase;
            cycleCount       <= nextCycle;
            emulData         <= nextBus;
            in12ClearN       <= !(nextStrobe && nextPhase == CLEAR);
            in12WriteCathode <= nextStrobe && nextPhase == CATHODE;
            in12WriteAnode   <= nextStrobe && nextPhase == ANODE;
            keyboardWrite    <= nextStrobe && nextPhase == KB_WRITE;
            keyboardRead     <= nextStrobe && nextPhase == KB_READ;
            frameDone        <= nextStrobe && nextPhase == STOP;
        end
    end

endmodule

/* rtl/nixieDigitMux.sv */
`timescale 1ns/1ps

module nixieDigitMux import ioDisplayPkg::*; (
    input  logic                                      Clock_1us,
    input  logic                                      rstN,
    input  logic                                      frameDone,
    input  logic [IP_DEKATRON_NUM*DEKATRON_WIDTH-1:0]   ipAddress,
    input  logic [AP_DEKATRON_NUM*DEKATRON_WIDTH-1:0]   apAddress,
    input  logic [DATA_DEKATRON_NUM*DEKATRON_WIDTH-1:0] apData,
    input  logic [LOOP_DEKATRON_NUM*DEKATRON_WIDTH-1:0] loopCounter,
    output logic [3:0]                                anodeIndex,
    output logic [7:0]                                cathodeData
);

    localparam int dw = DEKATRON_WIDTH;

    logic [dw-1:0] highDigit;
    logic [dw-1:0] lowDigit;

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            anodeIndex <= 4'd0;
        end else if (frameDone) begin
            if (anodeIndex == 4'(ANODE_COUNT - 1)) begin
                anodeIndex <= 4'd0;
            end else begin
                anodeIndex <= anodeIndex + 4'd1;
            end
        end
    end

    always_comb begin
        case (anodeIndex)
            4'd0: begin
                highDigit = loopCounter[0*dw +: dw];
                lowDigit  = apData[0*dw +: dw];
            end
            4'd1: begin
                highDigit = loopCounter[1*dw +: dw];
                lowDigit  = apData[1*dw +: dw];
            end
            4'd2: begin
                highDigit = loopCounter[2*dw +: dw];
                lowDigit  = apData[2*dw +: dw];
            end
            4'd3: begin
                highDigit = ipAddress[0*dw +: dw];
                lowDigit  = '0;
            end
            4'd4: begin
                highDigit = ipAddress[1*dw +: dw];
                lowDigit  = apAddress[0*dw +: dw];
            end
            4'd5: begin
                highDigit = ipAddress[2*dw +: dw];
                lowDigit  = apAddress[1*dw +: dw];
            end
            4'd6: begin
                highDigit = ipAddress[3*dw +: dw];
                lowDigit  = apAddress[2*dw +: dw];
            end
            4'd7: begin
                highDigit = ipAddress[4*dw +: dw];
                lowDigit  = apAddress[3*dw +: dw];
            end
            4'd8: begin
                highDigit = ipAddress[5*dw +: dw];
                lowDigit  = '0;
            end
            default: begin                         // Spare pair
                highDigit = '0;
                lowDigit  = '0;
            end
        endcase
    end

    assign cathodeData = {nixiePin(lowDigit), nixiePin(highDigit)};

endmodule

/* rtl/keyMatrixScanner.sv */
`timescale 1ns/1ps

module keyMatrixScanner import ioDisplayPkg::*; (
    input  logic                           Clock_1us,
    input  logic                           rstN,
    input  logic                           frameDone,
    input  logic                           keyboardRead,
    input  logic [KB_ROWS-1:0]             keyboardDataIn,
    output logic [KB_COLUMNS-1:0]          columnSelect,
    output logic [KB_COLUMNS*KB_ROWS-1:0]  keysState,
    output logic                           eventPush,
    output logic [KEY_CODE_WIDTH-1:0]      eventCode
);

    localparam int colWidth = $clog2(KB_COLUMNS);
    localparam int rowWidth = $clog2(KB_ROWS);

    logic [colWidth-1:0] column;
    logic [colWidth-1:0] pendColumn;
    logic [KB_ROWS-1:0]  pendRows;
    logic [KB_ROWS-1:0]  newPress;
    logic [rowWidth-1:0] firstRow;

    always_comb begin
        columnSelect         = '0;
        columnSelect[column] = 1'b1;
    end

    assign newPress = keyboardDataIn & ~keysState[column*KB_ROWS +: KB_ROWS];

    // Lowest pending row goes out first
    always_comb begin
        firstRow = '0;
        for (int r = KB_ROWS - 1; r >= 0; r--) begin
            if (pendRows[r]) begin
                firstRow = rowWidth'(r);
            end
        end
    end

    assign eventPush = |pendRows;
    assign eventCode = KEY_CODE_WIDTH'(pendColumn * KB_ROWS + firstRow);

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            column    <= '0;
            keysState <= '0;
            pendRows  <= '0;
        end else begin
            if (frameDone) begin
                column <= (column == colWidth'(KB_COLUMNS - 1)) ? '0 : column + 1'b1;
            end
            if (keyboardRead) begin
                keysState[column*KB_ROWS +: KB_ROWS] <= keyboardDataIn;
                pendRows                             <= newPress;
            end else if (eventPush) begin
                pendRows <= pendRows & ~(KB_ROWS'(1) << firstRow);
            end
        end
    end

    // Burst may run past the column advance
    always_ff @(posedge Clock_1us) begin
        if (keyboardRead) begin
            pendColumn <= column;
        end
    end

endmodule

/* rtl/keyEventLink.sv */
`timescale 1ns/1ps

module keyEventLink import ioDisplayPkg::*; (
    input  logic                      Clock_1us,
    input  logic                      rstN,
    input  logic                      eventPush,
    input  logic [KEY_CODE_WIDTH-1:0] eventCode,
    input  logic                      keyCreditReturn,
    output logic                      keyEventValid,
    output logic [KEY_CODE_WIDTH-1:0] keyEventCode,
    output logic                      eventOverflow
);

    localparam int ptrWidth    = $clog2(EVENT_FIFO_DEPTH);
    localparam int countWidth  = $clog2(EVENT_FIFO_DEPTH + 1);
    localparam int creditWidth = $clog2(KEY_CREDITS + 1);

    logic [KEY_CODE_WIDTH-1:0] fifoMem [EVENT_FIFO_DEPTH];
    logic [ptrWidth-1:0]       wrPtr;
    logic [ptrWidth-1:0]       rdPtr;
    logic [countWidth-1:0]     fillCount;
    logic [creditWidth-1:0]    credits;
    logic                      pushOk;
    logic                      sendNow;

    assign pushOk  = eventPush && (fillCount < countWidth'(EVENT_FIFO_DEPTH));
    assign sendNow = (fillCount != '0) && (credits != '0);

    assign keyEventValid = sendNow;
    assign keyEventCode  = fifoMem[rdPtr];

    always_ff @(posedge Clock_1us) begin
        if (pushOk) begin
            fifoMem[wrPtr] <= eventCode;
        end
    end

    always_ff @(posedge Clock_1us) begin
        if (!rstN) begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            fillCount     <= '0;
            credits       <= creditWidth'(KEY_CREDITS);
            eventOverflow <= 1'b0;
        end else begin
            if (pushOk) begin
                wrPtr <= (wrPtr == ptrWidth'(EVENT_FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (sendNow) begin
                rdPtr <= (rdPtr == ptrWidth'(EVENT_FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({pushOk, sendNow})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
            case ({keyCreditReturn, sendNow})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;     // Send and return cancel out
            endcase
            if (eventPush && !pushOk) begin
                eventOverflow <= 1'b1;           // Sticky until reset
            end
        end
    end

endmodule

/* rtl/ioKeyDisplayTop.sv */
`timescale 1ns/1ps

module ioKeyDisplayTop import ioDisplayPkg::*; #(
    parameter int scanDivisor = SCAN_DIVISOR_DEFAULT
) (
    input  logic                                      Clock_1us,
    input  logic                                      rstN,
    input  logic [KB_ROWS-1:0]                        keyboardDataIn,
    input  logic [IP_DEKATRON_NUM*DEKATRON_WIDTH-1:0]   ipAddress,
    input  logic [AP_DEKATRON_NUM*DEKATRON_WIDTH-1:0]   apAddress,
    input  logic [DATA_DEKATRON_NUM*DEKATRON_WIDTH-1:0] apData,
    input  logic [LOOP_DEKATRON_NUM*DEKATRON_WIDTH-1:0] loopCounter,
    input  logic                                      keyCreditReturn,
    output logic [7:0]                                emulData,
    output logic                                      in12WriteAnode,
    output logic                                      in12WriteCathode,
    output logic                                      in12ClearN,
    output logic                                      keyboardWrite,
    output logic                                      keyboardRead,
    output logic [KB_COLUMNS*KB_ROWS-1:0]             keysState,
    output logic                                      keyEventValid,
    output logic [KEY_CODE_WIDTH-1:0]                 keyEventCode,
    output logic                                      eventOverflow
);

    logic                      frameDone;
    logic [7:0]                cathodeData;
    logic [3:0]                anodeIndex;
    logic [KB_COLUMNS-1:0]     columnSelect;
    logic                      eventPush;
    logic [KEY_CODE_WIDTH-1:0] eventCode;

    busSequencer #(
        .scanDivisor(scanDivisor)
    ) u_busSequencer (
        .Clock_1us       (Clock_1us),
        .rstN            (rstN),
        .cathodeData     (cathodeData),
        .anodeIndex      (anodeIndex),
        .columnSelect    (columnSelect),
        .emulData        (emulData),
        .in12WriteAnode  (in12WriteAnode),
        .in12WriteCathode(in12WriteCathode),
        .in12ClearN      (in12ClearN),
        .keyboardWrite   (keyboardWrite),
        .keyboardRead    (keyboardRead),
        .frameDone       (frameDone)
    );

    nixieDigitMux u_nixieDigitMux (
        .Clock_1us  (Clock_1us),
        .rstN       (rstN),
        .frameDone  (frameDone),
        .ipAddress  (ipAddress),
        .apAddress  (apAddress),
        .apData     (apData),
        .loopCounter(loopCounter),
        .anodeIndex (anodeIndex),
        .cathodeData(cathodeData)
    );

    keyMatrixScanner u_keyMatrixScanner (
        .Clock_1us     (Clock_1us),
        .rstN          (rstN),
        .frameDone     (frameDone),
        .keyboardRead  (keyboardRead),
        .keyboardDataIn(keyboardDataIn),
        .columnSelect  (columnSelect),
        .keysState     (keysState),
        .eventPush     (eventPush),
        .eventCode     (eventCode)
    );

    keyEventLink u_keyEventLink (
        .Clock_1us      (Clock_1us),
        .rstN           (rstN),
        .eventPush      (eventPush),
        .eventCode      (eventCode),
        .keyCreditReturn(keyCreditReturn),
        .keyEventValid  (keyEventValid),
        .keyEventCode   (keyEventCode),
        .eventOverflow  (eventOverflow)
    );

endmodule

/* verification/ioKeyDisplayChecker.sv */
`timescale 1ns/1ps

module ioKeyDisplayChecker import ioDisplayPkg::*; #(
    parameter int scanDivisor = SCAN_DIVISOR_DEFAULT
) (
    input  logic        Clock_1us,
    input  logic        rstN,
    input  logic [4:0]  keyboardDataIn,
    input  logic [23:0] ipAddress,
    input  logic [15:0] apAddress,
    input  logic [11:0] apData,
    input  logic [11:0] loopCounter,
    input  logic        keyCreditReturn,
    input  logic [7:0]  emulData,
    input  logic        in12WriteAnode,
    input  logic        in12WriteCathode,
    input  logic        in12ClearN,
    input  logic        keyboardWrite,
    input  logic        keyboardRead,
    input  logic [39:0] keysState,
    input  logic        keyEventValid,
    input  logic [5:0]  keyEventCode,
    input  logic        eventOverflow,
    output int          errorCount,
    output int          checkCount,
    output int          framesSeen,
    output int          pendingEvents
);

    int                            cycle;
    int                            clearCycle;
    int                            strobeCount;
    int                            anodeCount;
    int                            columnCount;
    int                            credits;
    int                            pendColumn;
    logic [KB_ROWS-1:0]            pendRows;      // New presses still to be pushed
    logic [KB_COLUMNS*KB_ROWS-1:0] keyModel;
    logic                          overflowModel;
    logic                          afterReset;
    logic [KEY_CODE_WIDTH-1:0]     expQ [$];      // Events the link should hold

    initial begin
        errorCount    = 0;
        checkCount    = 0;
        framesSeen    = 0;
        pendingEvents = 0;
    end

    task automatic compare(input string name, input logic [39:0] expected,
                           input logic [39:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error at %0d ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic checkResetValues();
        compare("emulData", 0, emulData);
        compare("in12ClearN", 1, in12ClearN);
        compare("in12WriteCathode", 0, in12WriteCathode);
        compare("in12WriteAnode", 0, in12WriteAnode);
        compare("keyboardWrite", 0, keyboardWrite);
        compare("keyboardRead", 0, keyboardRead);
        compare("keyEventValid", 0, keyEventValid);
        compare("eventOverflow", 0, eventOverflow);
    endtask

    // Digit pair per anode from the display layout, low digit in the upper nibble
    function automatic logic [7:0] expectedCathode(input int idx);
        logic [3:0] hi;
        logic [3:0] lo;
        hi = 4'd0;
        lo = 4'd0;
        if (idx <= 2) begin
            hi = loopCounter[idx*4 +: 4];
            lo = apData[idx*4 +: 4];
        end else if (idx == 3 || idx == 8) begin
            hi = ipAddress[(idx == 3 ? 0 : 5)*4 +: 4];
        end else if (idx <= 7) begin
            hi = ipAddress[(idx - 3)*4 +: 4];
            lo = apAddress[(idx - 4)*4 +: 4];
        end
        return {nixiePin(lo), nixiePin(hi)};
    endfunction

    always @(negedge Clock_1us) begin : sample
        int   row;
        logic room;
        logic expSend;
        if (!rstN) begin
            checkResetValues();
            afterReset    = 1'b1;
            cycle         = 0;
            clearCycle    = -1000;
            strobeCount   = 0;
            anodeCount    = 0;
            columnCount   = 0;
            credits       = KEY_CREDITS;
            pendColumn    = 0;
            pendRows      = '0;
            keyModel      = '0;
            overflowModel = 1'b0;
            expQ.delete();
        end else begin
            cycle++;
            if (afterReset) begin
                checkResetValues();
                afterReset = 1'b0;
            end
            compare("keysState", keyModel, keysState);
            compare("eventOverflow", overflowModel, eventOverflow);

            // Room is judged on the fill level at the start of the cycle
            room    = expQ.size() < EVENT_FIFO_DEPTH;
            expSend = expQ.size() != 0 && credits != 0;
            compare("keyEventValid", expSend, keyEventValid);
            if (expSend) begin
                compare("keyEventCode", expQ[0], keyEventCode);
                void'(expQ.pop_front());
                credits--;
            end
            if (keyCreditReturn) begin
                credits++;
            end
            if (pendRows != '0) begin
                row = 0;
                while (!pendRows[row]) begin
                    row++;
                end
                if (room) begin
                    expQ.push_back(KEY_CODE_WIDTH'(pendColumn * KB_ROWS + row));
                end else begin
                    overflowModel = 1'b1;              // Dropped event
                end
                pendRows[row] = 1'b0;
            end

            if (!in12ClearN) begin
                if (framesSeen > 0) begin
                    compare("frame start cycle", clearCycle + scanDivisor, cycle);
                end else begin
                    // First frame opens scanDivisor cycles after reset
                    compare("first frame start cycle", scanDivisor + PHASE_CYCLES, cycle);
                end
                clearCycle  = cycle;
                strobeCount = 1;
                compare("emulData", 0, emulData);
            end
            if (in12WriteCathode) begin
                strobeCount++;
                compare("in12WriteCathode cycle", clearCycle + PHASE_CYCLES, cycle);
                compare("emulData", expectedCathode(anodeCount), emulData);
            end
            if (in12WriteAnode) begin
                strobeCount++;
                compare("in12WriteAnode cycle", clearCycle + 2 * PHASE_CYCLES, cycle);
                compare("emulData", anodeCount, emulData);
            end
            if (keyboardWrite) begin
                strobeCount++;
                compare("keyboardWrite cycle", clearCycle + 3 * PHASE_CYCLES, cycle);
                compare("emulData", 1 << columnCount, emulData);
            end
            if (keyboardRead) begin
                compare("keyboardRead cycle", clearCycle + 4 * PHASE_CYCLES, cycle);
                compare("strobes in frame", 4, strobeCount);
                compare("emulData", KB_READ_CODE, emulData);
                pendRows   = keyboardDataIn & ~keyModel[columnCount*KB_ROWS +: KB_ROWS];
                pendColumn = columnCount;
                keyModel[columnCount*KB_ROWS +: KB_ROWS] = keyboardDataIn;
                $display("frame %0d: anode %0d column %0d checked, %0d errors so far",
                         framesSeen, anodeCount, columnCount, errorCount);
                framesSeen++;
                anodeCount  = (anodeCount + 1) % ANODE_COUNT;
                columnCount = (columnCount + 1) % KB_COLUMNS;
            end
        end
        pendingEvents = expQ.size() + $countones(pendRows);
    end

endmodule

/* verification/ioKeyDisplayTb.sv */
`timescale 1ns/1ps

module ioKeyDisplayTb import ioDisplayPkg::*; ();

    localparam int scanDivisor = 64;
    localparam int frameRows   = 24;
    localparam int clockPeriod = 40;

    typedef struct packed {
        logic [23:0] ip;
        logic [15:0] ap;
        logic [11:0] data;
        logic [11:0] loop;
        logic [4:0]  rows;
        logic        hold;     // Host keeps its credits
    } frameRowT;

    frameRowT frames [frameRows];

    logic        Clock_1us;
    logic        rstN;
    logic [4:0]  keyboardDataIn;
    logic [23:0] ipAddress;
    logic [15:0] apAddress;
    logic [11:0] apData;
    logic [11:0] loopCounter;
    logic        keyCreditReturn;
    logic [7:0]  emulData;
    logic        in12WriteAnode;
    logic        in12WriteCathode;
    logic        in12ClearN;
    logic        keyboardWrite;
    logic        keyboardRead;
    logic [39:0] keysState;
    logic        keyEventValid;
    logic [5:0]  keyEventCode;
    logic        eventOverflow;
    int          errorCount;
    int          checkCount;
    int          framesSeen;
    int          pendingEvents;

    logic        withhold;
    int          cycle;
    int          returnDue [$];    // Cycle at which each credit goes back
    int          tbErrors;

    ioKeyDisplayTop #(.scanDivisor(scanDivisor)) u_ioKeyDisplayTop (.*);

    ioKeyDisplayChecker #(.scanDivisor(scanDivisor)) u_ioKeyDisplayChecker (.*);

    initial begin
        Clock_1us = 1'b0;
        forever #(clockPeriod / 2) Clock_1us = ~Clock_1us;
    end

    // ip, ap, data, loop, key rows of the frame's column, withhold
    task automatic loadTable();
        frames[0]  = '{24'h987654, 16'h3210, 12'h123, 12'h456, 5'b00101, 1'b0};
        frames[1]  = '{24'h102938, 16'h4756, 12'h9A1, 12'h0D7, 5'b00000, 1'b0};
        frames[2]  = '{24'h555555, 16'h1234, 12'h789, 12'h321, 5'b10010, 1'b0};
        frames[3]  = '{24'h12345F, 16'hABCD, 12'h000, 12'h999, 5'b11111, 1'b0};
        frames[4]  = '{24'h00A010, 16'h0009, 12'h876, 12'h543, 5'b01000, 1'b0};
        frames[5]  = '{24'h44B444, 16'h00E0, 12'h210, 12'h654, 5'b00000, 1'b0};
        frames[6]  = '{24'h091827, 16'h3645, 12'hFFF, 12'h111, 5'b10001, 1'b0};
        frames[7]  = '{24'h6A0000, 16'h8000, 12'h222, 12'h333, 5'b00110, 1'b0};
        frames[8]  = '{24'hC00000, 16'h0000, 12'h444, 12'h555, 5'b00111, 1'b0};
        frames[9]  = '{24'hFFFFFF, 16'hFFFF, 12'hFFF, 12'hFFF, 5'b00001, 1'b0};
        frames[10] = '{24'h000000, 16'h0000, 12'h00B, 12'h008, 5'b00000, 1'b0};
        frames[11] = '{24'h111111, 16'h2222, 12'h3A3, 12'h4C4, 5'b11111, 1'b0};
        frames[12] = '{24'h246802, 16'h1357, 12'h975, 12'h319, 5'b10111, 1'b1};
        frames[13] = '{24'h135790, 16'h2468, 12'h606, 12'h707, 5'b11100, 1'b1};
        frames[14] = '{24'hABCDEF, 16'h9876, 12'h543, 12'h210, 5'b10001, 1'b1};
        frames[15] = '{24'h7777E7, 16'h8888, 12'h999, 12'h000, 5'b00110, 1'b0};
        frames[16] = '{24'h800008, 16'h1111, 12'h2D2, 12'h303, 5'b00000, 1'b0};
        frames[17] = '{24'h001200, 16'h0034, 12'h560, 12'h780, 5'b00010, 1'b0};
        frames[18] = '{24'h314159, 16'h2653, 12'h589, 12'h793, 5'b01100, 1'b0};
        frames[19] = '{24'h27182F, 16'h2818, 12'h284, 12'h590, 5'b00000, 1'b0};
        frames[20] = '{24'h161803, 16'h3988, 12'h749, 12'h894, 5'b00000, 1'b0};
        frames[21] = '{24'h900009, 16'h5A5A, 12'h0F0, 12'h1E1, 5'b00011, 1'b0};
        frames[22] = '{24'h424242, 16'h4242, 12'h424, 12'h242, 5'b00000, 1'b0};
        frames[23] = '{24'hD00000, 16'h0EEE, 12'h876, 12'h123, 5'b11111, 1'b0};
    endtask

    task automatic applyRow(input int idx);
        ipAddress      = frames[idx].ip;
        apAddress      = frames[idx].ap;
        apData         = frames[idx].data;
        loopCounter    = frames[idx].loop;
        keyboardDataIn = frames[idx].rows;
        withhold       = frames[idx].hold;
    endtask

    task automatic waitForRead();
        @(negedge Clock_1us);
        while (!keyboardRead) begin
            @(negedge Clock_1us);
        end
    endtask

    initial begin : stimulus
        tbErrors       = 0;
        withhold       = 1'b0;
        rstN           = 1'b0;
        keyboardDataIn = '0;
        ipAddress      = '0;
        apAddress      = '0;
        apData         = '0;
        loopCounter    = '0;
        loadTable();
        repeat (2) @(posedge Clock_1us);
        #1;
        rstN = 1'b1;
        for (int i = 0; i < frameRows; i++) begin
            @(posedge Clock_1us);
            #1;
            applyRow(i);
            waitForRead();
            repeat (3) @(negedge Clock_1us);
        end
        @(posedge Clock_1us);
        while (pendingEvents != 0 || returnDue.size() != 0) begin
            @(posedge Clock_1us);
        end
        repeat (4) @(posedge Clock_1us);
        #1;
        if (framesSeen != frameRows) begin
            tbErrors++;
            $display("only %0d of %0d frames were scanned", framesSeen, frameRows);
        end
        if (!eventOverflow) begin
            tbErrors++;
            $display("the key event queue never reported an overflow");
        end
        $display("%0d checks done, %0d errors", checkCount, errorCount + tbErrors);
        if (errorCount == 0 && tbErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Host gives back one credit per received event after 1 to 8 cycles
    initial begin : hostCredits
        logic holding;
        void'($urandom(32'h7ee3));
        cycle           = 0;
        keyCreditReturn = 1'b0;
        forever begin
            @(negedge Clock_1us);
            if (rstN && keyEventValid) begin
                returnDue.push_back(cycle + 1 + int'($urandom % 8));
            end
            holding = withhold;
            @(posedge Clock_1us);
            cycle++;
            #1;
            keyCreditReturn = 1'b0;
            if (!holding && returnDue.size() != 0 && returnDue[0] <= cycle) begin
                void'(returnDue.pop_front());
                keyCreditReturn = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #((frameRows + 4) * scanDivisor * clockPeriod + 50 * clockPeriod);
        $display("timeout: the frames and key events did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* ioKeyDisplay.f */
rtl/ioDisplayPkg.sv
rtl/busSequencer.sv
rtl/nixieDigitMux.sv
rtl/keyMatrixScanner.sv
rtl/keyEventLink.sv
rtl/ioKeyDisplayTop.sv
verification/ioKeyDisplayChecker.sv
verification/ioKeyDisplayTb.sv

/* runSim.sh */
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing -Wno-fatal --top-module ioKeyDisplayTb \
    -f ioKeyDisplay.f -o ioKeyDisplaySim > build.log 2>&1 &&
./obj_dir/ioKeyDisplaySim > sim.log 2>&1 ||
echo "build or run stopped early, see build.log"
cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log &&
echo "run passed" ||
{ echo "run failed"; exit 1; }
